// File: common/ram_defines.svh
`ifndef RAM_DEFINES_SVH
`define RAM_DEFINES_SVH

// Chip geometry, 1024 x 4 per device
`define RAM_ADDR_BITS 10     // Address pins per chip
`define RAM_NIBBLES   4      // One chip per nibble of the word

// Bus side
`define BUS_ADDR_BITS 12     // Full bus address

// Top two bus address bits pick the board
// Everything below them goes straight to the chips
`define BOARD_SEL     2'b01

`endif

// File: common/bus_pkg.sv
`include "ram_defines.svh"

package bus_pkg;

    // One request from the processor bus
    // Strobes are single-cycle pulses, never both high
    typedef struct packed {
        logic                         rd;     // Read strobe
        logic                         wr;     // Write strobe
        logic [`BUS_ADDR_BITS-1:0]    addr;   // Board select + chip address
        logic [`RAM_NIBBLES-1:0]      mask;   // Nibble write mask, bit 0 = data[3:0]
        logic [`RAM_NIBBLES*4-1:0]    wdata;  // Write data
    } bus_req_t;

    // Read response back to the bus, no handshake
    typedef struct packed {
        logic                         rd_valid;  // One-cycle pulse
        logic [`RAM_NIBBLES*4-1:0]    rd_data;   // Held until the next read returns
    } bus_rsp_t;

endpackage

// File: common/ram_pkg.sv
`include "ram_defines.svh"

package ram_pkg;

    // Same 16 bits, two views
    // Bus side treats it as a word, chip wiring as per-chip nibbles
    typedef union packed {
        logic [`RAM_NIBBLES*4-1:0]       word;
        logic [`RAM_NIBBLES-1:0][3:0]    nib;   // nib[0] = bits 3:0 = chip 0
    } ram_word_u;

    // Request as seen on the chip pins, one shared for all four chips
    // Controls follow the Am9150 polarity
    typedef struct packed {
        logic                         rd;     // Read issued this cycle, for return tracking
        logic                         we_n;   // Shared write enable
        logic [`RAM_NIBBLES-1:0]      cs_n;   // One select per chip
        logic [`RAM_ADDR_BITS-1:0]    addr;   // Shared address
        ram_word_u                    data;   // Write data, split per chip
    } chip_ctrl_t;

endpackage

// File: am9150/am9150_w_clock.sv
`include "ram_defines.svh"

// Clocked model of a 1024 x 4 Am9150 static RAM
// Separate data in and out, registered read
// No array reset here, block RAM cannot clear in one shot
module am9150_w_clock (
    input  logic                         clk,
    input  logic [`RAM_ADDR_BITS-1:0]    address,
    input  logic [3:0]                   data_in,
    output logic [3:0]                   data_out,
    input  logic                         write_enable_n,
    input  logic                         chip_select_n,
    input  logic                         output_enable_n,
    input  logic                         RESET_n
);

    logic [3:0] mem [0:(1 << `RAM_ADDR_BITS)-1];   // Storage array

    logic do_write;
    logic do_read;

    // Reset low blocks all accesses
    assign do_write = !chip_select_n && !write_enable_n && RESET_n;

    // Read needs select, output enable, and no write in progress
    assign do_read  = !chip_select_n && !output_enable_n && write_enable_n && RESET_n;

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[address] <= data_in;
        end
    end

    // Output register
    always_ff @(posedge clk) begin
        if (do_read) begin
            data_out <= mem[address];   // Valid one cycle after the request
        end else begin
            data_out <= 4'b0;           // Stands in for the floating bus
        end
    end

endmodule

// File: rtl/bus_decode.sv
`include "ram_defines.svh"

// Bus side of the board
// Window match, busy drop, and strobe to chip control conversion
module bus_decode (
    input  logic                   clk,
    input  logic                   RESET_n,
    input  bus_pkg::bus_req_t      bus_req,
    input  logic                   busy,
    output ram_pkg::chip_ctrl_t    chip_req
);

    logic                  in_window;
    logic                  accept_rd;
    logic                  accept_wr;
    ram_pkg::chip_ctrl_t   req_next;

    // Top address bits select this board
    assign in_window = (bus_req.addr[`BUS_ADDR_BITS-1:`RAM_ADDR_BITS] == `BOARD_SEL);

    // Nothing gets through while a clear owns the chips
    assign accept_rd = bus_req.rd && in_window && !busy;
    assign accept_wr = bus_req.wr && in_window && !busy;

    always_comb begin
        req_next           = '0;
        req_next.we_n      = 1'b1;                                // Idle is a read level
        req_next.cs_n      = '1;                                  // No chip selected
        req_next.addr      = bus_req.addr[`RAM_ADDR_BITS-1:0];
        req_next.data.word = bus_req.wdata;
        if (accept_rd) begin
            req_next.rd   = 1'b1;
            req_next.cs_n = '0;                                   // Whole word
        end else if (accept_wr) begin
            // Masked nibbles only, the rest keep their contents
            req_next.we_n = 1'b0;
            req_next.cs_n = ~bus_req.mask;
        end
    end

    // One pipeline stage
    always_ff @(posedge clk) begin
        chip_req.addr <= req_next.addr;   // Payload, don't care when unselected
        chip_req.data <= req_next.data;
        if (!RESET_n) begin
            chip_req.rd   <= 1'b0;
            chip_req.we_n <= 1'b1;
            chip_req.cs_n <= '1;
        end else begin
            chip_req.rd   <= req_next.rd;
            chip_req.we_n <= req_next.we_n;
            chip_req.cs_n <= req_next.cs_n;
        end
    end

endmodule

// File: rtl/clear_sequencer.sv
`include "ram_defines.svh"

// Zero-fill of the whole array
// Stands in for the chip's own reset function
// Runs from system reset and on each clear_req pulse
module clear_sequencer (
    input  logic                   clk,
    input  logic                   RESET_n,
    input  logic                   clear_req,
    input  ram_pkg::chip_ctrl_t    bus_chip_req,
    output ram_pkg::chip_ctrl_t    chip_req,
    output logic                   busy
);

    logic [`RAM_ADDR_BITS-1:0]   clr_addr;   // Walk position
    logic                        busy_q;
    ram_pkg::chip_ctrl_t         clr_req;

    always_ff @(posedge clk) begin
        if (!RESET_n) begin
            busy_q   <= 1'b1;               // Power-on clear starts right away
            clr_addr <= '0;
        end else if (clear_req) begin
            busy_q   <= 1'b1;               // A pulse mid-clear restarts the walk
            clr_addr <= '0;
        end else if (busy_q) begin
            clr_addr <= clr_addr + 1'b1;    // Wraps back to 0 at the end
            if (clr_addr == '1) begin
                busy_q <= 1'b0;             // Last address written this cycle
            end
        end
    end

    // Zero write to every chip at once
    always_comb begin
        clr_req           = '0;
        clr_req.rd        = 1'b0;
        clr_req.we_n      = 1'b0;
        clr_req.cs_n      = '0;
        clr_req.addr      = clr_addr;
        clr_req.data.word = '0;
    end

    // No extra stage on the bus path
    assign chip_req = busy_q ? clr_req : bus_chip_req;
    assign busy     = busy_q;

endmodule

// File: rtl/read_return.sv
// Output side
// Lines the read flag up with the chip output register,
// then registers the word and a one-cycle valid
module read_return (
    input  logic                   clk,
    input  logic                   RESET_n,
    input  logic                   rd_issued,
    input  ram_pkg::ram_word_u     chip_data,
    output bus_pkg::bus_rsp_t      bus_rsp
);

    logic rd_pending;   // Read whose data is on the chip outputs now

    always_ff @(posedge clk) begin
        if (!RESET_n) begin
            rd_pending       <= 1'b0;
            bus_rsp.rd_valid <= 1'b0;
        end else begin
            rd_pending       <= rd_issued;    // Chip latency, one cycle
            bus_rsp.rd_valid <= rd_pending;   // High one cycle per read
        end
    end

    // Data register, loads only for a returning read
    // Back-to-back reads load every cycle, in order
    always_ff @(posedge clk) begin
        if (rd_pending) begin
            bus_rsp.rd_data <= chip_data.word;
        end
    end

endmodule

// File: rtl/nibble_ram_board.sv
`include "ram_defines.svh"

// 1K x 16 RAM board, four Am9150 chips, one per nibble
// Path is decode, clear mux, chips, read return
// Read strobe to rd_valid is 3 cycles
module nibble_ram_board (
    input  logic                 clk,
    input  logic                 RESET_n,
    input  bus_pkg::bus_req_t    bus_req,
    input  logic                 clear_req,
    output bus_pkg::bus_rsp_t    bus_rsp,
    output logic                 busy
);

    ram_pkg::chip_ctrl_t   bus_chip_req;   // From the decoder
    ram_pkg::chip_ctrl_t   chip_req;       // What the chips actually see
    ram_pkg::ram_word_u    chip_data;      // Joined chip outputs

    bus_decode i_bus_decode (
        .clk      (clk),
        .RESET_n  (RESET_n),
        .bus_req  (bus_req),
        .busy     (busy),
        .chip_req (bus_chip_req)
    );

    clear_sequencer i_clear_sequencer (
        .clk          (clk),
        .RESET_n      (RESET_n),
        .clear_req    (clear_req),
        .bus_chip_req (bus_chip_req),
        .chip_req     (chip_req),
        .busy         (busy)
    );

    // Chip i holds bits 4*i+3 : 4*i of every word
    for (genvar i = 0; i < `RAM_NIBBLES; i++) begin : g_chip
        am9150_w_clock i_chip (
            .clk             (clk),
            .address         (chip_req.addr),
            .data_in         (chip_req.data.nib[i]),
            .data_out        (chip_data.nib[i]),
            .write_enable_n  (chip_req.we_n),
            .chip_select_n   (chip_req.cs_n[i]),
            .output_enable_n (1'b0),             // Always enabled, chip gates reads itself
            .RESET_n         (RESET_n)
        );
    end

    read_return i_read_return (
        .clk       (clk),
        .RESET_n   (RESET_n),
        .rd_issued (chip_req.rd),   // Zero during a clear, so no return
        .chip_data (chip_data),
        .bus_rsp   (bus_rsp)
    );

endmodule

// File: test/nibble_ram_board_checker.sv
// Timing and clear-walk properties of the board
// chip_req.rd marks a read that reached the chips one cycle after the strobe
module nibble_ram_board_checker (
    input logic                  clk,
    input logic                  RESET_n,
    input logic                  busy,
    input ram_pkg::chip_ctrl_t   chip_req,
    input bus_pkg::bus_rsp_t     bus_rsp
);

    int unsigned busy_run;   // Consecutive cycles with busy high

    always_ff @(posedge clk) begin
        if (!RESET_n) begin
            busy_run <= 0;
        end else if (busy) begin
            busy_run <= busy_run + 1;
        end else begin
            busy_run <= 0;               // Restarts with the next clear
        end
    end

    // rd_valid only 3 cycles after an accepted strobe
    a_valid_after_read: assert property (@(posedge clk) disable iff (!RESET_n)
        bus_rsp.rd_valid |-> $past(chip_req.rd, 2))
        else $error("rd_valid without an accepted read three cycles earlier");

    // And every accepted read does come back
    a_read_returns: assert property (@(posedge clk) disable iff (!RESET_n)
        $past(chip_req.rd, 2) |-> bus_rsp.rd_valid)
        else $error("accepted read gave no rd_valid");

    // Only zeros go in while the clear owns the chips
    a_clear_writes_zero: assert property (@(posedge clk) disable iff (!RESET_n)
        busy && !chip_req.we_n |-> chip_req.data.word == '0)
        else $error("chip write with nonzero data while busy");

    // Full walk before busy drops
    a_clear_length: assert property (@(posedge clk) disable iff (!RESET_n)
        $fell(busy) |-> busy_run >= 1024)
        else $error("busy fell before 1024 cycles of clearing");

endmodule

bind nibble_ram_board nibble_ram_board_checker i_checker (
    .clk      (clk),
    .RESET_n  (RESET_n),
    .busy     (busy),
    .chip_req (chip_req),
    .bus_rsp  (bus_rsp)
);

// File: test/nibble_ram_board_tb.sv
`include "ram_defines.svh"

// Stim-file driven testbench for the 1K x 16 RAM board
// Reads queue up and each response is matched mid-cycle against the oldest one
module nibble_ram_board_tb;

    localparam int IDLE_TIMEOUT  = 3000;   // Cycles allowed for a 1024-cycle clear
    localparam int DRAIN_TIMEOUT = 8;      // Cycles for reads in flight to come back

    logic                clk;
    logic                RESET_n;
    logic                clear_req;
    bus_pkg::bus_req_t   bus_req;
    bus_pkg::bus_rsp_t   bus_rsp;
    logic                busy;

    int     cycle        = 0;      // Rising edges seen by the stimulus process
    int     errors       = 0;
    int     test_errors  = 0;      // Current test only
    int     tests_run    = 0;
    int     tests_failed = 0;
    bit     aborted      = 1'b0;
    string  cur_name     = "";

    string                       pend_name[$];    // Reads in flight with the oldest first
    logic [`RAM_NIBBLES*4-1:0]   pend_data[$];
    int                          pend_cycle[$];   // Cycle of the read strobe

    nibble_ram_board i_dut (
        .clk       (clk),
        .RESET_n   (RESET_n),
        .bus_req   (bus_req),
        .clear_req (clear_req),
        .bus_rsp   (bus_rsp),
        .busy      (busy)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic void count_error();
        errors++;
        test_errors++;
    endfunction

    // Every rd_valid belongs to the oldest read exactly 3 cycles on
    function automatic void check_response();
        if (bus_rsp.rd_valid === 1'b1) begin
            if (pend_data.size() == 0) begin
                $display("test %0s: rd_valid came with no read in flight", cur_name);
                count_error();
            end else begin
                if (cycle - pend_cycle[0] != 3) begin
                    $display("error %0s: read latency expected 3 actual %0d",
                             pend_name[0], cycle - pend_cycle[0]);
                    count_error();
                end
                if (bus_rsp.rd_data !== pend_data[0]) begin
                    $display("error %0s: rd_data expected %h actual %h",
                             pend_name[0], pend_data[0], bus_rsp.rd_data);
                    count_error();
                end
                pend_name.delete(0);
                pend_data.delete(0);
                pend_cycle.delete(0);
            end
        end
    endfunction

    // Check at the falling edge and stop just after the next rising one
    task automatic next_cycle();
        @(negedge clk);
        check_response();
        @(posedge clk);
        #1;                                // Input drive point
        cycle++;
    endtask

    task automatic wait_not_busy();
        int n;
        n = 0;
        while (busy && n < IDLE_TIMEOUT) begin
            next_cycle();
            n++;
        end
        if (busy) begin
            $display("test %0s: busy still high after %0d cycles", cur_name, IDLE_TIMEOUT);
            count_error();
            aborted = 1'b1;
        end
    endtask

    task automatic end_test();
        int n;
        n = 0;
        while (pend_data.size() != 0 && n < DRAIN_TIMEOUT) begin
            next_cycle();
            n++;
        end
        if (pend_data.size() != 0) begin
            $display("test %0s: %0d reads never got rd_valid", cur_name, pend_data.size());
            count_error();
            pend_name.delete();
            pend_data.delete();
            pend_cycle.delete();
        end
        repeat (3) begin
            next_cycle();                  // Dropped reads would answer by now
        end
        tests_run++;
        if (test_errors == 0) begin
            $display("test %0s: ok", cur_name);
        end else begin
            $display("test %0s: %0d errors", cur_name, test_errors);
            tests_failed++;
        end
    endtask

    initial begin
        int                          fd;
        int                          n;
        string                       line;
        string                       name;
        string                       op;
        logic [`BUS_ADDR_BITS-1:0]   addr;
        logic [`RAM_NIBBLES-1:0]     mask;
        logic [`RAM_NIBBLES*4-1:0]   data;
        logic [`RAM_NIBBLES*4-1:0]   expv;
        RESET_n   = 1'b0;
        clear_req = 1'b0;
        bus_req   = '0;
        repeat (4) @(posedge clk);
        #1;
        RESET_n = 1'b1;                    // Power-on clear starts here
        fd = $fopen("test/nibble_ram_board_stim.txt", "r");
        if (fd == 0) begin
            $display("stim file test/nibble_ram_board_stim.txt could not be opened");
            errors++;
            aborted = 1'b1;
        end
        while (!aborted && !$feof(fd)) begin
            n = $fgets(line, fd);
            if (n == 0 || line.len() < 4 || line.substr(0, 0) == "#") begin
                continue;                  // Blank or comment
            end
            n = $sscanf(line, "%s %s %h %h %h %h", name, op, addr, mask, data, expv);
            if (n != 6) begin
                $display("stim line not understood: %0s", line);
                errors++;
                continue;
            end
            if (name != cur_name) begin
                if (cur_name != "") begin
                    end_test();
                end
                cur_name    = name;
                test_errors = 0;
            end
            if (op == "wait_idle") begin
                wait_not_busy();
            end else if (op == "read" || op == "write" || op == "clear") begin
                bus_req.rd    = (op == "read");
                bus_req.wr    = (op == "write");
                bus_req.addr  = addr;
                bus_req.mask  = mask;
                bus_req.wdata = data;
                clear_req     = (op == "clear");
                if (op == "read" && mask != '0) begin   // Mask 0 on a read means no answer is due
                    pend_name.push_back(name);
                    pend_data.push_back(expv);
                    pend_cycle.push_back(cycle);
                end
                next_cycle();
                bus_req.rd = 1'b0;         // Strobes last one cycle
                bus_req.wr = 1'b0;
                clear_req  = 1'b0;
                if (op == "clear" && busy !== 1'b1) begin   // Busy rises right after the pulse
                    $display("error %0s: busy expected 1 actual %b", name, busy);
                    count_error();
                end
            end else begin
                $display("test %0s: unknown operation %0s", name, op);
                count_error();
            end
        end
        if (cur_name != "") begin
            end_test();
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        if (aborted) begin
            $display("run stopped early after a timeout or a missing stim file");
        end
        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: test/nibble_ram_board_stim.txt
# name  op  bus_addr  mask  wdata  expected   (hex fields)
# read with mask f expects rd_valid and the expected word, mask 0 expects no rd_valid
power_on   wait_idle  000  0  0000  0000
power_on   read       400  f  0000  0000
power_on   read       5a5  f  0000  0000
power_on   read       7ff  f  0000  0000
full_word  write      412  f  beef  0000
full_word  read       412  f  0000  beef
full_word  write      7fe  f  1234  0000
full_word  read       7fe  f  0000  1234
nib_mask   write      430  f  a5c3  0000
nib_mask   write      430  5  7171  0000
nib_mask   read       430  f  0000  a1c1
nib_mask   write      430  8  f000  0000
nib_mask   write      430  0  ffff  0000
nib_mask   read       430  f  0000  f1c1
window     write      4a5  f  5555  0000
window     write      0a5  f  dead  0000
window     read       0a5  0  0000  0000
window     write      ca5  f  beef  0000
window     read       8a5  0  0000  0000
window     read       4a5  f  0000  5555
pipeline   write      401  f  1111  0000
pipeline   write      402  f  2222  0000
pipeline   write      403  f  3333  0000
pipeline   read       401  f  0000  1111
pipeline   read       402  f  0000  2222
pipeline   read       403  f  0000  3333
pipeline   read       412  f  0000  beef
clear_req  clear      000  0  0000  0000
clear_req  read       412  0  0000  0000
clear_req  write      413  f  9999  0000
clear_req  wait_idle  000  0  0000  0000
clear_req  read       412  f  0000  0000
clear_req  read       403  f  0000  0000
clear_req  read       413  f  0000  0000

// File: nibble_ram_board.f
+incdir+common
common/bus_pkg.sv
common/ram_pkg.sv
am9150/am9150_w_clock.sv
rtl/bus_decode.sv
rtl/clear_sequencer.sv
rtl/read_return.sv
rtl/nibble_ram_board.sv
test/nibble_ram_board_checker.sv
test/nibble_ram_board_tb.sv

// File: run_sim.sh
#!/bin/sh
# Verilator build and run of the RAM board testbench

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f nibble_ram_board.f \
    --top-module nibble_ram_board_tb \
    -o sim_nibble_ram_board > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/sim_nibble_ram_board > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi

if grep -F -x -q "*** TEST PASSED ***" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
